//--- source/conv1_pkg.sv
package conv1_pkg;

  // data widths
  localparam int PIX_W     = 8;                     // signed pixel
  localparam int WGT_W     = 8;                     // signed weight
  localparam int PROD_W    = PIX_W + WGT_W;         // full product of one tap, 16b
  localparam int PSUM_W    = 20;                    // 9 products of 16b fit without wrap

  // kernel and array geometry
  localparam int TAPS      = 3;                     // kernel width
  localparam int PE_ROWS   = 3;                     // kernel height, one pe per row
  localparam int FILT_W    = TAPS * WGT_W;          // one kernel row, byte c = tap c
  localparam int PIX_BUS_W = PE_ROWS * PIX_W;       // three stacked pixel rows

  // image geometry
  localparam int IMG_W     = 16;                    // columns per image row
  localparam int COL_W     = $clog2(IMG_W + 1);     // col counter has to hold IMG_W itself

  // pipeline timing, in enable steps
  // tap reg + product reg + psum reg through PE0, plus one psum hop per lower PE
  localparam int PIPE_LAT  = 5;

  // weight load bookkeeping
  localparam int LD_CNT_W  = $clog2(PE_ROWS + 1);   // counts loads up to PE_ROWS

  // weight state of the column
  typedef enum logic [1:0] {
    ST_EMPTY,                                       // nothing loaded since reset
    ST_LOADING,                                     // some rows in, chain not full
    ST_READY                                        // every pe holds a kernel row
  } ctrl_state_e;

endpackage

//--- source/tap_shift_register.sv
`timescale 1ns/10ps
module tap_shift_register (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        en,          // global step enable
  input  logic [conv1_pkg::PIX_W-1:0] pix_in,      // next pixel of this row
  output logic [conv1_pkg::PIX_W-1:0] tap_0,       // newest pixel
  output logic [conv1_pkg::PIX_W-1:0] tap_1,       // one step older
  output logic [conv1_pkg::PIX_W-1:0] tap_2        // oldest pixel of the window
);

  import conv1_pkg::*;

  // three-deep window over the pixel row
  // taps show a pixel one step after it is presented
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tap_0 <= '0;                                  // empty window after reset
      tap_1 <= '0;
      tap_2 <= '0;
    end else if (en) begin
      tap_0 <= pix_in;                              // newest in
      tap_1 <= tap_0;                               // age by one column
      tap_2 <= tap_1;                               // old tap_2 drops out
    end
  end

endmodule

//--- source/mult_pipe.sv
`timescale 1ns/10ps
module mult_pipe (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         en,         // clock enable of the multiplier
  input  logic [conv1_pkg::PIX_W-1:0]  a,          // signed pixel
  input  logic [conv1_pkg::WGT_W-1:0]  b,          // signed weight
  output logic [conv1_pkg::PROD_W-1:0] p           // signed product, one step late
);

  import conv1_pkg::*;

  logic signed [PROD_W-1:0] prod_d;                 // combinational product

  // both operands signed so the 16b result is a true signed product
  assign prod_d = $signed(a) * $signed(b);

  // behavioral stand-in for the registered multiplier ip
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p <= '0;                                      // product reg clears on reset
    end else if (en) begin
      p <= prod_d;                                  // capture on enable step only
    end
  end

endmodule

//--- source/pe_unit_conv1.sv
`timescale 1ns/10ps
module pe_unit_conv1 (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         en,          // global step enable
  input  logic                         weight_load, // shift kernel rows, ignores en
  input  logic [conv1_pkg::FILT_W-1:0] filt_in,     // kernel row from pe above or top
  input  logic [conv1_pkg::PIX_W-1:0]  pix_in,      // pixel row, already skewed
  input  logic [conv1_pkg::PSUM_W-1:0] psum_in,     // partial sum from pe above
  output logic [conv1_pkg::FILT_W-1:0] filt_out,    // held kernel row, feeds pe below
  output logic [conv1_pkg::PIX_W-1:0]  pix_out,     // newest tap forwarded
  output logic [conv1_pkg::PSUM_W-1:0] psum_out     // registered partial sum
);

  import conv1_pkg::*;

  logic [FILT_W-1:0] wgt_q;                         // kernel row held by this pe
  logic [PIX_W-1:0]  tap   [TAPS];                  // window, index 0 newest
  logic [PROD_W-1:0] prod  [TAPS];                  // registered tap products
  logic [PSUM_W-1:0] prod_ext [TAPS];               // products sign extended to psum width
  logic [PSUM_W-1:0] psum_d;                        // next partial sum

  // weight register, loads on every strobe so the three pes act as one shift path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wgt_q <= '0;                                  // no kernel after reset
    end else if (weight_load) begin
      wgt_q <= filt_in;                             // take row from above
    end
  end

  assign filt_out = wgt_q;                          // old row moves one pe down

  // pixel window of this kernel row
  tap_shift_register i_taps (
    .clk    (clk),
    .rst_n  (rst_n),
    .en     (en),
    .pix_in (pix_in),
    .tap_0  (tap[0]),
    .tap_1  (tap[1]),
    .tap_2  (tap[2])
  );

  assign pix_out = tap[0];                          // unused at top, kept for chaining

  // one registered multiplier per tap, weight byte c times tap c
  for (genvar c = 0; c < TAPS; c++) begin : g_mult
    mult_pipe i_mult (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (en),
      .a     (tap[c]),
      .b     (wgt_q[c*WGT_W +: WGT_W]),
      .p     (prod[c])
    );

    // replicate sign bit up to psum width
    assign prod_ext[c] = {{(PSUM_W-PROD_W){prod[c][PROD_W-1]}}, prod[c]};
  end

  // two's complement sum, 20b wide enough so no wrap
  assign psum_d = psum_in + prod_ext[0] + prod_ext[1] + prod_ext[2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psum_out <= '0;                               // chain starts clean
    end else if (en) begin
      psum_out <= psum_d;                           // one step after the products
    end
  end

  // frozen step must not disturb the sum handed to the next pe
  a_psum_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !en |=> $stable(psum_out)
  );

endmodule

//--- source/row_skew.sv
`timescale 1ns/10ps
module row_skew (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            en,       // global step enable
  input  logic [conv1_pkg::PIX_BUS_W-1:0] pix_in,   // byte k is row k, row 0 on top
  output logic [conv1_pkg::PIX_W-1:0]     row_0,    // no delay
  output logic [conv1_pkg::PIX_W-1:0]     row_1,    // one step late
  output logic [conv1_pkg::PIX_W-1:0]     row_2     // two steps late
);

  import conv1_pkg::*;

  logic [PIX_W-1:0] row_1_q;                        // single stage for row 1
  logic [PIX_W-1:0] row_2_q [2];                    // two stages for row 2

  // each lower pe sees its psum one step after the pe above,
  // so its pixels must arrive that much later too
  assign row_0 = pix_in[0*PIX_W +: PIX_W];          // pe0 heads the chain

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_1_q    <= '0;
      row_2_q[0] <= '0;
      row_2_q[1] <= '0;
    end else if (en) begin
      row_1_q    <= pix_in[1*PIX_W +: PIX_W];       // row 1 one step behind
      row_2_q[0] <= pix_in[2*PIX_W +: PIX_W];       // row 2 first stage
      row_2_q[1] <= row_2_q[0];                     // row 2 second stage
    end
  end

  assign row_1 = row_1_q;
  assign row_2 = row_2_q[1];

endmodule

//--- source/conv1_ctrl.sv
`timescale 1ns/10ps
module conv1_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic en,                                  // global step enable
  input  logic row_start,                           // this step carries column 0
  input  logic weight_load,                         // kernel row shift strobe
  output logic weights_ready,                       // all pes hold a kernel row
  output logic out_valid                            // psum_out window fully inside row
);

  import conv1_pkg::*;

  ctrl_state_e         state;                       // weight state
  ctrl_state_e         state_next;
  logic [LD_CNT_W-1:0] load_cnt;                    // loads seen, saturates at PE_ROWS
  logic [COL_W-1:0]    col_cnt;                     // index the next column will get
  logic [COL_W-1:0]    col_idx;                     // index of the column on this step
  logic                win_ok;                      // full 3 wide window this column
  logic [PIPE_LAT-1:0] vld_pipe;                    // window flags in flight

  // weight state machine, runs on load strobes even with en low
  always_comb begin
    state_next = state;
    case (state)
      ST_EMPTY: begin
        if (weight_load) state_next = ST_LOADING;   // first row in
      end
      ST_LOADING: begin
        if (weight_load && (load_cnt == LD_CNT_W'(PE_ROWS - 1))) begin
          state_next = ST_READY;                    // last pe filled
        end
      end
      default: begin
        state_next = state;                         // extra loads just shift kernel
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= ST_EMPTY;
      load_cnt      <= '0;
      weights_ready <= 1'b0;
    end else begin
      state         <= state_next;
      weights_ready <= (state_next == ST_READY);    // registered copy of ready state
      if (weight_load && (load_cnt != LD_CNT_W'(PE_ROWS))) begin
        load_cnt <= load_cnt + 1'b1;                // stop counting once full
      end
    end
  end

  // column position, row_start forces column 0 on this same step
  assign col_idx = row_start ? '0 : col_cnt;

  // window needs TAPS-1 older columns of the same row
  assign win_ok = (col_idx >= COL_W'(TAPS - 1)) &&
                  (col_idx <  COL_W'(IMG_W)) &&
                  weights_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt  <= COL_W'(IMG_W);                    // parked until first row_start
      vld_pipe <= '0;
    end else if (en) begin
      if (col_idx < COL_W'(IMG_W)) begin
        col_cnt <= col_idx + 1'b1;
      end else begin
        col_cnt <= COL_W'(IMG_W);                   // saturate past end of row
      end
      vld_pipe <= {vld_pipe[PIPE_LAT-2:0], win_ok}; // follows the data pipe step by step
    end
  end

  assign out_valid = vld_pipe[PIPE_LAT-1];          // lines up with pe2 psum

  // ready flag and state register never disagree
  a_ready_state: assert property (
    @(posedge clk) disable iff (!rst_n)
    weights_ready == (state == ST_READY)
  );

  // no valid result before the kernel is complete
  a_valid_after_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> weights_ready
  );

endmodule

//--- source/conv1_column_top.sv
`timescale 1ns/10ps
module conv1_column_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            en,            // freezes all data state when low
  input  logic                            row_start,     // column 0 of a new row
  input  logic [conv1_pkg::PIX_BUS_W-1:0] pix_in,        // three pixel rows, row 0 in byte 0
  input  logic                            weight_load,   // shift kernel rows down
  input  logic [conv1_pkg::FILT_W-1:0]    weight_in,     // kernel row into pe0
  output logic                            weights_ready,
  output logic [conv1_pkg::PSUM_W-1:0]    psum_out,      // 3x3 result from pe2
  output logic                            out_valid
);

  import conv1_pkg::*;

  logic [PIX_W-1:0]  row_0, row_1, row_2;           // skewed pixel rows
  logic [FILT_W-1:0] filt_0, filt_1;                // weight shift path pe0->pe1->pe2
  logic [PSUM_W-1:0] psum_0, psum_1;                // psum chain pe0->pe1->pe2

  row_skew i_skew (
    .clk    (clk),
    .rst_n  (rst_n),
    .en     (en),
    .pix_in (pix_in),
    .row_0  (row_0),
    .row_1  (row_1),
    .row_2  (row_2)
  );

  pe_unit_conv1 i_pe_0 (                            // top kernel row, chain head
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .weight_load (weight_load),
    .filt_in     (weight_in),
    .pix_in      (row_0),
    .psum_in     ('0),                              // nothing above pe0
    .filt_out    (filt_0),
    .pix_out     (),
    .psum_out    (psum_0)
  );

  pe_unit_conv1 i_pe_1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .weight_load (weight_load),
    .filt_in     (filt_0),
    .pix_in      (row_1),
    .psum_in     (psum_0),
    .filt_out    (filt_1),
    .pix_out     (),
    .psum_out    (psum_1)
  );

  pe_unit_conv1 i_pe_2 (                            // bottom row, oldest loaded kernel row
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .weight_load (weight_load),
    .filt_in     (filt_1),
    .pix_in      (row_2),
    .psum_in     (psum_1),
    .filt_out    (),                                // row shifted past pe2 is dropped
    .pix_out     (),
    .psum_out    (psum_out)
  );

  conv1_ctrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .row_start     (row_start),
    .weight_load   (weight_load),
    .weights_ready (weights_ready),
    .out_valid     (out_valid)
  );

endmodule

//--- tb/conv1_tb_tasks.svh
`ifndef CONV1_TB_TASKS_SVH
`define CONV1_TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  check_count++;
  if (exp !== act) begin
    error_count++;
    $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
  end
endtask

// one kernel row into pe0 with ready checked once the strobe has landed
task automatic load_row(input logic [FILT_W-1:0] row);
  @(posedge clk);
  en          <= 1'b0;                              // loads happen with the pipe frozen
  row_start   <= 1'b0;
  weight_load <= 1'b1;
  weight_in   <= row;
  @(posedge clk);
  weight_load <= 1'b0;
  @(posedge clk);
  loads_given++;
  check_value("weights_ready", (loads_given >= PE_ROWS), weights_ready);
endtask

task automatic send_column(input logic [PIX_BUS_W-1:0] col, input logic start,
                           input int max_gap);
  int gap;
  gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
  repeat (gap) begin
    @(posedge clk);
    en        <= 1'b0;
    row_start <= 1'b0;
    pix_in    <= PIX_BUS_W'($urandom());           // junk while frozen
  end
  @(posedge clk);
  en        <= 1'b1;                                // column taken on the next edge
  row_start <= start;
  pix_in    <= col;
endtask

task automatic send_row(input int n_cols, input int max_gap);
  for (int n = 0; n < n_cols; n++) begin
    send_column(row_buf[n], (n == 0), max_gap);
  end
endtask

// zero columns until the last real result has left PE2
task automatic flush_pipe();
  repeat (PIPE_LAT + 1) send_column('0, 1'b0, 0);
  @(posedge clk);
  en        <= 1'b0;
  row_start <= 1'b0;
endtask

task automatic fill_random_row();
  for (int n = 0; n < IMG_W; n++) begin
    row_buf[n] = PIX_BUS_W'($urandom());
  end
endtask

task automatic expect_valid_count(input int exp);
  check_value("valid_count", exp, valid_psum_q.size());
endtask

task automatic ready_after_loads();
  @(posedge clk);
  check_value("weights_ready", 1'b0, weights_ready);
  check_value("out_valid", 1'b0, out_valid);
  valid_psum_q.delete();
  fill_random_row();
  send_row(IMG_W, 0);                               // no kernel yet so nothing valid
  flush_pipe();
  expect_valid_count(0);
  load_row(24'h000000);                             // kernel row 2
  load_row(24'h000000);                             // kernel row 1
  load_row(24'h000001);                             // kernel row 0 with tap 0 = 1
endtask

task automatic identity_kernel_row();
  logic [PSUM_W-1:0] exp_pix;
  valid_psum_q.delete();
  fill_random_row();
  send_row(IMG_W, 0);
  flush_pipe();
  expect_valid_count(IMG_W - 2);
  if (valid_psum_q.size() == IMG_W - 2) begin
    for (int n = 2; n < IMG_W; n++) begin
      exp_pix = PSUM_W'($signed(row_buf[n][PIX_W-1:0]));  // row 0 pixel sign extended
      check_value("psum_out", exp_pix, valid_psum_q[n-2]);
    end
  end
endtask

task automatic random_kernel_row();
  logic [FILT_W-1:0] krow [PE_ROWS];
  for (int r = 0; r < PE_ROWS; r++) begin
    krow[r] = FILT_W'($urandom());
  end
  krow[0][WGT_W-1:0]      = 8'h80;                  // -128 on row 0 tap 0
  krow[2][FILT_W-1 -: 8]  = 8'h7f;                  // 127 on row 2 tap 2
  load_row(krow[2]);                                // bottom row first
  load_row(krow[1]);
  load_row(krow[0]);
  valid_psum_q.delete();
  valid_exp_q.delete();
  fill_random_row();
  row_buf[4] = 24'h80_7f_80;                        // extreme pixels in the window
  row_buf[9] = 24'h7f_80_7f;
  send_row(IMG_W, 0);
  flush_pipe();
  expect_valid_count(IMG_W - 2);
  gap_ref_q = valid_exp_q;
endtask

// same row and kernel with en dropped at random
task automatic enable_gap_row();
  valid_psum_q.delete();
  send_row(IMG_W, MAX_GAP);
  flush_pipe();
  expect_valid_count(IMG_W - 2);
  if (valid_psum_q.size() == gap_ref_q.size()) begin
    for (int i = 0; i < gap_ref_q.size(); i++) begin
      check_value("psum_out", gap_ref_q[i], valid_psum_q[i]);
    end
  end
endtask

task automatic fourth_load_shift();
  load_row(FILT_W'($urandom()));                    // old pe2 row drops out
  valid_psum_q.delete();
  fill_random_row();
  send_row(IMG_W, 0);
  flush_pipe();
  expect_valid_count(IMG_W - 2);
endtask

task automatic mid_row_restart();
  valid_psum_q.delete();
  fill_random_row();
  send_row(9, 0);                                   // row cut short at column 9
  fill_random_row();
  send_row(IMG_W, 0);                               // restart straight away
  flush_pipe();
  expect_valid_count((9 - 2) + (IMG_W - 2));
endtask

`endif

//--- tb/conv1_tb.sv
`timescale 1ns/10ps
module conv1_tb;

  import conv1_pkg::*;

  localparam int RST_CYC     = 10;                  // reset length in clocks
  localparam int MAX_GAP     = 2;                   // most en-low clocks before one column
  localparam int ROW_CYC     = IMG_W + PIPE_LAT + 3;                 // row plus flush
  localparam int GAP_ROW_CYC = IMG_W * (MAX_GAP + 1) + PIPE_LAT + 3; // row with en gaps
  localparam int LOAD_CYC    = 3;                   // clocks per weight load
  localparam int N_LOADS     = 7;                   // 3 identity + 3 random + 1 extra
  localparam int STIM_CYC    = RST_CYC + 6 * ROW_CYC + GAP_ROW_CYC + N_LOADS * LOAD_CYC;
  localparam int TIMEOUT_CYC = 2 * STIM_CYC;        // twice the stimulus length

  logic                 clk;
  logic                 rst_n;
  logic                 en;
  logic                 row_start;
  logic [PIX_BUS_W-1:0] pix_in;
  logic                 weight_load;
  logic [FILT_W-1:0]    weight_in;
  logic                 weights_ready;
  logic [PSUM_W-1:0]    psum_out;
  logic                 out_valid;

  int error_count;                                  // mismatches seen
  int check_count;                                  // compares done
  int cycle_cnt;                                    // watchdog count
  int loads_given;                                  // weight_load strobes issued

  logic [PIX_BUS_W-1:0] row_buf [IMG_W];            // columns of the row being streamed
  logic [PSUM_W-1:0]    valid_psum_q [$];           // dut psum on each valid step
  logic [PSUM_W-1:0]    valid_exp_q [$];            // model psum on each valid step
  logic [PSUM_W-1:0]    gap_ref_q [$];              // model results of the random row

  // reference model state
  logic signed [WGT_W-1:0] kern [PE_ROWS][TAPS];    // kern[r][c] is row r tap c
  logic signed [PIX_W-1:0] hist [PE_ROWS][TAPS];    // hist[r][c] = x_r[n-c]
  int                      load_seen;               // loads since reset
  int                      col_model;               // index the next column gets
  logic [PSUM_W-1:0]       exp_psum_q [$];          // expected psum, one per enable step
  logic                    exp_vld_q [$];           // expected out_valid for the same steps

  conv1_column_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .row_start     (row_start),
    .pix_in        (pix_in),
    .weight_load   (weight_load),
    .weight_in     (weight_in),
    .weights_ready (weights_ready),
    .psum_out      (psum_out),
    .out_valid     (out_valid)
  );

  always #20 clk = ~clk;                            // 40 ns period

  `include "conv1_tb_tasks.svh"

  // 3x3 rule per enable step with the result due PIPE_LAT steps later
  always @(posedge clk) begin : ref_model
    int                sum;
    int                idx;
    logic [PSUM_W-1:0] exp_p;
    logic              exp_v;
    if (!rst_n) begin
      for (int r = 0; r < PE_ROWS; r++) begin
        for (int c = 0; c < TAPS; c++) begin
          kern[r][c] = '0;
          hist[r][c] = '0;                          // zero columns before the first step
        end
      end
      load_seen = 0;
      col_model = IMG_W;                            // no row open yet
      exp_psum_q.delete();
      exp_vld_q.delete();
      repeat (PIPE_LAT) begin
        exp_psum_q.push_back('0);                   // pipe holds zeros after reset
        exp_vld_q.push_back(1'b0);
      end
    end else begin
      if (en) begin
        exp_p = exp_psum_q.pop_front();             // column from PIPE_LAT steps ago
        exp_v = exp_vld_q.pop_front();
        check_value("out_valid", exp_v, out_valid);
        if (exp_v) begin
          check_value("psum_out", exp_p, psum_out);
          valid_exp_q.push_back(exp_p);
        end
        if (out_valid) begin
          valid_psum_q.push_back(psum_out);
        end
        sum = 0;
        for (int r = 0; r < PE_ROWS; r++) begin
          hist[r][2] = hist[r][1];
          hist[r][1] = hist[r][0];
          hist[r][0] = pix_in[r*PIX_W +: PIX_W];    // byte r is row r
          for (int c = 0; c < TAPS; c++) begin
            sum = sum + kern[r][c] * hist[r][c];
          end
        end
        idx = row_start ? 0 : col_model;
        exp_psum_q.push_back(PSUM_W'(sum));
        exp_vld_q.push_back((idx >= TAPS - 1) && (idx < IMG_W) && (load_seen >= PE_ROWS));
        col_model = (idx < IMG_W) ? idx + 1 : IMG_W;  // saturate after the row
      end
      if (weight_load) begin
        for (int r = PE_ROWS - 1; r > 0; r--) begin
          for (int c = 0; c < TAPS; c++) begin
            kern[r][c] = kern[r-1][c];              // older rows move down
          end
        end
        for (int c = 0; c < TAPS; c++) begin
          kern[0][c] = weight_in[c*WGT_W +: WGT_W];
        end
        load_seen++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: tests still running after %0d clock cycles", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    en          = 1'b0;
    row_start   = 1'b0;
    pix_in      = '0;
    weight_load = 1'b0;
    weight_in   = '0;
    error_count = 0;
    check_count = 0;
    cycle_cnt   = 0;
    loads_given = 0;
    void'($urandom(32'haa74));                      // one seed for the whole run
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    ready_after_loads();
    identity_kernel_row();
    random_kernel_row();
    enable_gap_row();
    fourth_load_shift();
    mid_row_restart();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tb
source/conv1_pkg.sv
source/tap_shift_register.sv
source/mult_pipe.sv
source/pe_unit_conv1.sv
source/row_skew.sv
source/conv1_ctrl.sv
source/conv1_column_top.sv
tb/conv1_tb.sv
